// ==== filelist.f ====
+incdir+rtl
rtl/ps2KbPkg.sv
rtl/ps2FrameRx.sv
rtl/scanCodeFifo.sv
rtl/kbMmioRegs.sv
rtl/ps2KbTop.sv
testbench/ps2KbChecker.sv
testbench/ps2KbTb.sv

// ==== Makefile ====
TOP = ps2KbTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== testbench/ps2KbTb.sv ====
/*
 * Testbench for the PS/2 keyboard controller.
 * Seeded random PS/2 frames, some corrupted, mixed with MMIO traffic,
 * then overrun, resync and address decode phases.
 */

`timescale 1ns/1ps

`include "kb_consts.svh"

module ps2KbTb import ps2KbPkg::*; ();

	localparam int NumRandFrames = 40;
	localparam int NumOverFrames = 20;
	localparam int HalfBit = 8;
	localparam int MinGap = 20;
	localparam int MaxGap = 35;
	localparam logic [31:0] Base = `KB_MMIO_BASE;
	localparam logic [31:0] DataAddr = Base | {28'd0, `KB_REG_DATA, 2'b00};
	localparam logic [31:0] StatusAddr = Base | {28'd0, `KB_REG_STATUS, 2'b00};
	localparam logic [31:0] UnusedAddr = Base | 32'h4;
	localparam mmioReq_t IdleReq = '0;

	// frames, the resync gap and MMIO traffic, in clocks
	localparam int FrameCycles = 22 * HalfBit + MaxGap;
	localparam int MmioCycles = (NumRandFrames * 3 + 80) * 5;
	localparam int RunCycles = 10 + (NumRandFrames + NumOverFrames + 2) * FrameCycles
		+ `KB_IDLE_CYCLES + 300 + MmioCycles;

	logic		clock;
	logic		rst_i;
	logic		ps2Clk;
	logic		ps2Data;
	mmioReq_t	mmioReq;
	mmioRsp_t	mmioRsp;
	int			checkCount;
	int			errorCount;

	ps2KbTop dut_i (
		.clock		(clock),
		.rst_i		(rst_i),
		.ps2Clk_i	(ps2Clk),
		.ps2Data_i	(ps2Data),
		.mmioReq_i	(mmioReq),
		.mmioRsp_o	(mmioRsp)
	);

	ps2KbChecker checker_i (
		.clock			(clock),
		.rst_i			(rst_i),
		.ps2Clk_i		(ps2Clk),
		.ps2Data_i		(ps2Data),
		.mmioReq_i		(mmioReq),
		.mmioRsp_i		(mmioRsp),
		.checkCount_o	(checkCount),
		.errorCount_o	(errorCount)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial
	begin
		#(RunCycles * 6);
		$display("watchdog expired after %0d clocks, stimulus never finished",
			RunCycles * 3 / 2);
		$display("Simulation FAILED");
		$finish;
	end

	function automatic int randRange(input int lo, input int hi);
		return lo + int'($urandom % 32'(hi - lo + 1));
	endfunction

	function automatic logic [31:0] outsideAddr();
		logic [31:0] a;
		a = $urandom;
		if (a[31:4] == Base[31:4])
			a[20] = ~a[20];
		return a;
	endfunction

	// data changes while the PS/2 clock is high
	task automatic sendBit(input logic b);
		ps2Data <= b;
		repeat (HalfBit) @(posedge clock);
		ps2Clk <= 1'b0;
		repeat (HalfBit) @(posedge clock);
		ps2Clk <= 1'b1;
	endtask

	// kind 1 flips parity, kind 2 sends a low stop bit
	task automatic sendFrame(input logic [7:0] code, input int kind);
		logic	parity;
		logic	stop;
		int		b;
		parity = ~^code;
		stop = (kind == 2) ? 1'b0 : 1'b1;
		if (kind == 1)
			parity = ~parity;
		sendBit(1'b0);
		for (b = 0; b < 8; b++)
			sendBit(code[b]);
		sendBit(parity);
		sendBit(stop);
		ps2Data <= 1'b1;
		repeat (randRange(MinGap, MaxGap)) @(posedge clock);
	endtask

	task automatic mmioAccess(input logic rd, input logic wr, input logic [31:0] addr);
		mmioReq <= '{read: rd, write: wr, addr: addr, opm: 5'($urandom)};
		@(posedge clock);
		mmioReq <= IdleReq;
		repeat (randRange(1, 3)) @(posedge clock);
	endtask

	task automatic randomMmioBurst();
		int pick;
		repeat (randRange(1, 3))
		begin
			pick = randRange(0, 99);
			if (pick < 55)
				mmioAccess(1'b1, 1'b0, DataAddr);
			else if (pick < 75)
				mmioAccess(1'b1, 1'b0, StatusAddr);
			else if (pick < 80)
				mmioAccess(1'b0, 1'b1, StatusAddr);
			else if (pick < 85)
				mmioAccess(1'b0, 1'b1, DataAddr);
			else if (pick < 90)
				mmioAccess(1'b1, 1'b0, UnusedAddr);
			else
				mmioAccess(1'b1, 1'b0, outsideAddr());
		end
	endtask

	initial
	begin
		int i;
		int kind;
		logic rdSel;
		void'($urandom(32'he3e2));
		rst_i = 1'b1;
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		mmioReq = IdleReq;
		repeat (10) @(posedge clock);
		rst_i <= 1'b0;
		repeat (5) @(posedge clock);

		// random frames, about one in ten corrupted
		for (i = 0; i < NumRandFrames; i++)
		begin
			kind = (randRange(0, 9) == 0) ? randRange(1, 2) : 0;
			sendFrame(8'($urandom), kind);
			if (randRange(0, 1) == 1)
				randomMmioBurst();
		end

		// drain past empty, then clear counters
		repeat (NumOverFrames) mmioAccess(1'b1, 1'b0, DataAddr);
		mmioAccess(1'b1, 1'b0, StatusAddr);
		mmioAccess(1'b0, 1'b1, StatusAddr);
		mmioAccess(1'b1, 1'b0, StatusAddr);

		// back-pressure, more frames than queue slots
		repeat (NumOverFrames) sendFrame(8'($urandom), 0);
		mmioAccess(1'b1, 1'b0, StatusAddr);
		repeat (NumOverFrames) mmioAccess(1'b1, 1'b0, DataAddr);
		mmioAccess(1'b1, 1'b0, StatusAddr);
		mmioAccess(1'b0, 1'b1, StatusAddr);
		mmioAccess(1'b1, 1'b0, StatusAddr);

		// partial frame, idle gap, then a clean frame
		sendBit(1'b0);
		repeat (4) sendBit(1'($urandom));
		ps2Data <= 1'b1;
		repeat (`KB_IDLE_CYCLES + 300) @(posedge clock);
		sendFrame(8'($urandom), 0);
		mmioAccess(1'b1, 1'b0, DataAddr);
		mmioAccess(1'b1, 1'b0, DataAddr);
		mmioAccess(1'b1, 1'b0, StatusAddr);

		// address decode, every access is a real read or write
		repeat (12)
		begin
			rdSel = 1'(randRange(0, 1));
			mmioAccess(rdSel, !rdSel, outsideAddr());
		end
		mmioAccess(1'b1, 1'b0, UnusedAddr);
		mmioAccess(1'b0, 1'b1, DataAddr);

		repeat (10) @(posedge clock);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== testbench/ps2KbChecker.sv ====
/*
 * Scoreboard for the PS/2 keyboard controller.
 * Decodes frames from the PS/2 pins, keeps a model queue and model
 * counters, and predicts every MMIO response one cycle ahead.
 */

`timescale 1ns/1ps

`include "kb_consts.svh"

module ps2KbChecker import ps2KbPkg::*; (
	input  logic		clock,
	input  logic		rst_i,
	input  logic		ps2Clk_i,
	input  logic		ps2Data_i,
	input  mmioReq_t	mmioReq_i,
	input  mmioRsp_t	mmioRsp_i,
	output int			checkCount_o,
	output int			errorCount_o
);

	localparam logic [31:0] Base = `KB_MMIO_BASE;

	logic [7:0]		modelQ[$];
	logic [7:0]		errModel;
	logic [7:0]		overModel;
	int				checks = 0;
	int				errors = 0;

	// pin-level frame decode
	logic			clkSeen;
	logic [10:0]	frameBits;
	int				bitsIn;
	longint			cycle = 0;
	longint			lastEdge;

	// response due on the next edge
	logic			expOk;
	logic			expWordValid;
	logic [31:0]	expWord;
	string			expName;

	assign checkCount_o = checks;
	assign errorCount_o = errors;

	task automatic reportMismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[ERROR] %0t %s: expected %h, actual %h", $time, name, exp, act);
		errors++;
	endtask

	// start 0, stop 1, odd parity over data and parity bits
	task automatic judgeFrame(input logic [10:0] f);
		logic good;
		good = (f[0] == 1'b0) && (f[10] == 1'b1) && (^f[9:1] == 1'b1);
		if (!good)
			errModel = (errModel == 8'hFF) ? errModel : errModel + 8'd1;
		else if (modelQ.size() < `KB_FIFO_DEPTH)
			modelQ.push_back(f[8:1]);
		else
			overModel = (overModel == 8'hFF) ? overModel : overModel + 8'd1;
	endtask

	task automatic decodePins();
		if (clkSeen && !ps2Clk_i)
		begin
			// a long quiet spell abandons a half received frame
			if (cycle - lastEdge > `KB_IDLE_CYCLES)
				bitsIn = 0;
			lastEdge = cycle;
			frameBits = {ps2Data_i, frameBits[10:1]};
			bitsIn++;
			if (bitsIn == 11)
			begin
				judgeFrame(frameBits);
				bitsIn = 0;
			end
		end
		clkSeen = ps2Clk_i;
	endtask

	task automatic predictRequest();
		logic [1:0]	offset;
		logic [7:0]	code;
		int			fill;
		offset = mmioReq_i.addr[3:2];
		fill = modelQ.size();
		expOk = 1'b0;
		expWordValid = 1'b0;
		expWord = '0;
		expName = "idle";
		if (!(mmioReq_i.read || mmioReq_i.write))
			return;
		if (mmioReq_i.addr[31:4] != Base[31:4])
		begin
			expName = "outsideBase";
			return;
		end
		expOk = 1'b1;
		if (mmioReq_i.write)
		begin
			expName = "writeAck";
			if (offset == `KB_REG_STATUS)
			begin
				errModel = '0;
				overModel = '0;
			end
			return;
		end
		expWordValid = 1'b1;
		if (offset == `KB_REG_DATA)
		begin
			expName = "dataRead";
			if (fill != 0)
			begin
				code = modelQ.pop_front();
				expWord = {23'd0, 1'b1, code};
			end
		end
		else if (offset == `KB_REG_STATUS)
		begin
			expName = "statusRead";
			expWord = {3'd0, 5'(fill), overModel, errModel, 7'd0, fill != 0};
		end
		else
			expName = "unusedRead";
	endtask

	task automatic compareResponse();
		checks++;
		if (mmioRsp_i.ok !== expOk)
			reportMismatch({expName, " ok"}, 32'(expOk), 32'(mmioRsp_i.ok));
		else if (expOk && expWordValid && mmioRsp_i.word !== expWord)
			reportMismatch(expName, expWord, mmioRsp_i.word);
	endtask

	always @(posedge clock)
	begin
		cycle++;
		if (rst_i)
		begin
			modelQ.delete();
			errModel = '0;
			overModel = '0;
			clkSeen = 1'b1;
			bitsIn = 0;
			lastEdge = cycle;
			expOk = 1'b0;
			expWordValid = 1'b0;
			expName = "idle";
		end
		else
		begin
			compareResponse();
			decodePins();
			predictRequest();
		end
	end

endmodule

// ==== rtl/ps2KbTop.sv ====
/*
 * PS/2 keyboard controller top.
 * Receive-only frame receiver, scan-code queue and MMIO registers.
 */

`timescale 1ns/1ps

module ps2KbTop import ps2KbPkg::*; (
	input  logic		clock,
	input  logic		rst_i,
	input  logic		ps2Clk_i,
	input  logic		ps2Data_i,
	input  mmioReq_t	mmioReq_i,
	output mmioRsp_t	mmioRsp_o
);

	scanPush_t		scanPush;
	rxErrors_t		rxErrors;
	logic			creditRet;
	logic			clearErrors;
	logic			pop;
	logic [7:0]		head;
	logic			empty;
	logic [4:0]		level;

	ps2FrameRx frameRx_i (
		.clock			(clock),
		.rst_i			(rst_i),
		.ps2Clk_i		(ps2Clk_i),
		.ps2Data_i		(ps2Data_i),
		.creditRet_i	(creditRet),
		.clearErrors_i	(clearErrors),
		.push_o			(scanPush),
		.errors_o		(rxErrors)
	);

	scanCodeFifo fifo_i (
		.clock			(clock),
		.rst_i			(rst_i),
		.push_i			(scanPush),
		.pop_i			(pop),
		.head_o			(head),
		.empty_o		(empty),
		.level_o		(level),
		.creditRet_o	(creditRet)
	);

	kbMmioRegs regs_i (
		.clock			(clock),
		.rst_i			(rst_i),
		.mmioReq_i		(mmioReq_i),
		.head_i			(head),
		.empty_i		(empty),
		.level_i		(level),
		.errors_i		(rxErrors),
		.pop_o			(pop),
		.clearErrors_o	(clearErrors),
		.mmioRsp_o		(mmioRsp_o)
	);

endmodule

// ==== rtl/kbMmioRegs.sv ====
/*
 * Keyboard register block.
 * Decodes MMIO requests against the base address, returns DATA and
 * STATUS words one cycle later, pops the queue on DATA reads and
 * clears the error counters on STATUS writes.
 */

`timescale 1ns/1ps

`include "kb_consts.svh"

module kbMmioRegs import ps2KbPkg::*; (
	input  logic		clock,
	input  logic		rst_i,
	input  mmioReq_t	mmioReq_i,
	input  logic [7:0]	head_i,
	input  logic		empty_i,
	input  logic [4:0]	level_i,
	input  rxErrors_t	errors_i,
	output logic		pop_o,
	output logic		clearErrors_o,
	output mmioRsp_t	mmioRsp_o
);

	localparam logic [31:0] Base = `KB_MMIO_BASE;

	logic				hit;
	logic [1:0]			offset;
	logic				rdReq;
	logic				wrReq;
	mmioWord_u			rdWord;

	logic				rspOk;
	logic [31:0]		rspWord;

	assign hit = (mmioReq_i.addr[31:4] == Base[31:4]);
	assign offset = mmioReq_i.addr[3:2];
	assign rdReq = mmioReq_i.read && hit;
	assign wrReq = mmioReq_i.write && hit;

	// read word, decoded per register
	always_comb
	begin
		rdWord = '0;
		if (rdReq && offset == `KB_REG_DATA)
		begin
			rdWord.dataView.valid	= !empty_i;
			rdWord.dataView.code	= empty_i ? 8'h00 : head_i;
		end
		else if (rdReq && offset == `KB_REG_STATUS)
		begin
			rdWord.statusView.level			= level_i;
			rdWord.statusView.overrunCount	= errors_i.overrunCount;
			rdWord.statusView.errCount		= errors_i.errCount;
			rdWord.statusView.nonEmpty		= !empty_i;
		end
	end

	// head is consumed in the same cycle it is captured
	assign pop_o = rdReq && (offset == `KB_REG_DATA) && !empty_i;
	assign clearErrors_o = wrReq && (offset == `KB_REG_STATUS);

	always_ff @(posedge clock)
	begin
		if (rst_i)
			rspOk <= 1'b0;
		else
			rspOk <= rdReq || wrReq;
	end

	always_ff @(posedge clock)
	begin
		rspWord <= rdWord;
	end

	assign mmioRsp_o = '{ok: rspOk, word: rspWord};

	// status level and non-empty flag come from two queue outputs that must agree
	levelMatchesEmpty: assert property (@(posedge clock) disable iff (rst_i)
		empty_i == (level_i == '0));

endmodule

// ==== rtl/scanCodeFifo.sv ====
/*
 * Scan-code queue.
 * Circular buffer between the frame receiver and the register block.
 * Head is read combinationally, each accepted pop returns one credit.
 */

`timescale 1ns/1ps

`include "kb_consts.svh"

module scanCodeFifo import ps2KbPkg::*; #(
	parameter int DEPTH = `KB_FIFO_DEPTH
) (
	input  logic		clock,
	input  logic		rst_i,
	input  scanPush_t	push_i,
	input  logic		pop_i,
	output logic [7:0]	head_o,
	output logic		empty_o,
	output logic [4:0]	level_o,
	output logic		creditRet_o
);

	localparam int AddrW = $clog2(DEPTH);

	logic [7:0]			mem [DEPTH];
	logic [AddrW-1:0]	wrPtr;
	logic [AddrW-1:0]	rdPtr;
	logic [AddrW:0]		count;
	logic				full;
	logic				doPush;
	logic				doPop;
	logic				creditRet;

	assign full = (count == (AddrW+1)'(DEPTH));
	assign empty_o = (count == '0);

	assign doPush = push_i.valid && !full;
	assign doPop = pop_i && !empty_o;

	always_ff @(posedge clock)
	begin
		if (doPush)
			mem[wrPtr] <= push_i.code;
	end

	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			count	<= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (!doPush && doPop)
				count <= count - 1'b1;
		end
	end

	// credit goes back the cycle after the pop
	always_ff @(posedge clock)
	begin
		if (rst_i)
			creditRet <= 1'b0;
		else
			creditRet <= doPop;
	end

	assign head_o = mem[rdPtr];
	assign level_o = 5'(count);
	assign creditRet_o = creditRet;

	// receiver credits should keep pushes away from a full queue
	noPushFull: assert property (@(posedge clock) disable iff (rst_i)
		push_i.valid |-> !full);

	// register block only pops when it saw data
	noPopEmpty: assert property (@(posedge clock) disable iff (rst_i)
		pop_i |-> !empty_o);

endmodule

// ==== rtl/ps2FrameRx.sv ====
/*
 * PS/2 frame receiver.
 * Synchronizes the PS/2 lines, shifts in 11-bit frames on falling clock
 * edges, checks start, stop and odd parity, and pushes good scan codes
 * to the queue while credits remain. Keeps saturating error counters.
 */

`timescale 1ns/1ps

`include "kb_consts.svh"

module ps2FrameRx import ps2KbPkg::*; (
	input  logic		clock,
	input  logic		rst_i,
	input  logic		ps2Clk_i,
	input  logic		ps2Data_i,
	input  logic		creditRet_i,
	input  logic		clearErrors_i,
	output scanPush_t	push_o,
	output rxErrors_t	errors_o
);

	localparam int CreditW = $clog2(`KB_FIFO_DEPTH + 1);
	localparam int IdleW = $clog2(`KB_IDLE_CYCLES + 1);
	localparam logic [CreditW-1:0] CreditMax = CreditW'(`KB_FIFO_DEPTH);
	localparam logic [IdleW-1:0] IdleMax = IdleW'(`KB_IDLE_CYCLES);

	logic [1:0]			clkSync;
	logic [1:0]			dataSync;
	logic				clkPrev;
	logic				fallEdge;

	logic [10:0]		window;
	logic [10:0]		nextWindow;
	logic [3:0]			bitCount;
	logic [IdleW-1:0]	idleCount;

	logic				frameDone;
	logic				frameOk;
	logic				take;

	logic [CreditW-1:0]	creditCount;
	logic [7:0]			errCount;
	logic [7:0]			overrunCount;

	logic				pushValid;
	logic [7:0]			pushCode;

	// two-flop synchronizers, lines idle high
	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			clkSync	<= 2'b11;
			clkPrev	<= 1'b1;
		end
		else
		begin
			clkSync	<= {clkSync[0], ps2Clk_i};
			clkPrev	<= clkSync[1];
		end
	end

	always_ff @(posedge clock)
	begin
		dataSync <= {dataSync[0], ps2Data_i};
	end

	assign fallEdge = clkPrev && !clkSync[1];

	// bits arrive lsb first, start bit ends up in window[0]
	assign nextWindow = {dataSync[1], window[10:1]};

	assign frameDone = fallEdge && (bitCount == 4'd10);
	assign frameOk = !nextWindow[0] && nextWindow[10] && (^nextWindow[9:1]);
	assign take = frameDone && frameOk && (creditCount != '0);

	always_ff @(posedge clock)
	begin
		if (fallEdge)
			window <= nextWindow;
	end

	// bit counter with idle timeout
	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			bitCount	<= '0;
			idleCount	<= '0;
		end
		else if (fallEdge)
		begin
			bitCount	<= (bitCount == 4'd10) ? 4'd0 : bitCount + 4'd1;
			idleCount	<= '0;
		end
		else
		begin
			if (idleCount == IdleMax)
				bitCount <= '0;
			else
				idleCount <= idleCount + 1'b1;
		end
	end

	// one credit per queue slot
	always_ff @(posedge clock)
	begin
		if (rst_i)
			creditCount <= CreditMax;
		else if (take && !creditRet_i)
			creditCount <= creditCount - 1'b1;
		else if (!take && creditRet_i)
			creditCount <= creditCount + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (rst_i || clearErrors_i)
		begin
			errCount		<= '0;
			overrunCount	<= '0;
		end
		else if (frameDone)
		begin
			if (!frameOk && errCount != 8'hFF)
				errCount <= errCount + 8'd1;
			// good frame with no room, device cannot be held off
			if (frameOk && creditCount == '0 && overrunCount != 8'hFF)
				overrunCount <= overrunCount + 8'd1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst_i)
			pushValid <= 1'b0;
		else
			pushValid <= take;
	end

	always_ff @(posedge clock)
	begin
		if (frameDone)
			pushCode <= nextWindow[8:1];
	end

	assign push_o = '{valid: pushValid, code: pushCode};
	assign errors_o = '{errCount: errCount, overrunCount: overrunCount};

	// queue must never hand back more credits than it has slots
	creditBound: assert property (@(posedge clock) disable iff (rst_i)
		creditCount <= CreditMax);

endmodule

// ==== rtl/ps2KbPkg.sv ====
/*
 * PS/2 keyboard controller types.
 * Receiver push word, error counters, MMIO request and response,
 * and the two decodings of the MMIO read word.
 */

package ps2KbPkg;

	// receiver to queue
	typedef struct packed {
		logic			valid;
		logic [7:0]		code;
	} scanPush_t;

	// both counters saturate at 255
	typedef struct packed {
		logic [7:0]		errCount;
		logic [7:0]		overrunCount;
	} rxErrors_t;

	// opm bits are carried for bus compatibility only
	typedef struct packed {
		logic			read;
		logic			write;
		logic [31:0]	addr;
		logic [4:0]		opm;
	} mmioReq_t;

	typedef struct packed {
		logic			ok;
		logic [31:0]	word;
	} mmioRsp_t;

	// DATA register view
	typedef struct packed {
		logic [22:0]	zero;
		logic			valid;
		logic [7:0]		code;
	} mmioData_t;

	// STATUS register view
	typedef struct packed {
		logic [2:0]		zeroHi;
		logic [4:0]		level;
		logic [7:0]		overrunCount;
		logic [7:0]		errCount;
		logic [6:0]		zeroLo;
		logic			nonEmpty;
	} mmioStatus_t;

	typedef union packed {
		mmioData_t		dataView;
		mmioStatus_t	statusView;
	} mmioWord_u;

endpackage

// ==== rtl/kb_consts.svh ====
/*
 * PS/2 keyboard controller constants.
 * Queue depth, register map and receiver idle timeout.
 */

`ifndef KB_CONSTS_SVH
`define KB_CONSTS_SVH

// scan codes held in the receive queue
`define KB_FIFO_DEPTH	16

// register block base, bits above bit 3 must match
`define KB_MMIO_BASE	32'hF000_E040

// word offsets within the block, taken from address bits [3:2]
`define KB_REG_DATA		2'd0
`define KB_REG_STATUS	2'd2

// system clocks without a PS/2 clock edge before a partial frame is dropped
`define KB_IDLE_CYCLES	2000

`endif
